// ==== files.f ====
logic/periph_pkg.sv
logic/periph_bus_if.sv
logic/uart_fifo.sv
logic/uart_serial.sv
logic/uart_ctrl.sv
logic/periph_decode.sv
logic/periph_soc.sv
verif/periph_soc_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the peripheral block testbench with Verilator and run it.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   -f files.f --top-module periph_soc_tb -o sim_periph
build_status=$?
if [ $build_status -ne 0 ]; then
   echo "Verilator build failed with status $build_status"
   exit 1
fi

sim_out=$(./obj_dir/sim_periph)
run_status=$?
printf '%s\n' "$sim_out"
if [ $run_status -ne 0 ]; then
   echo "Simulation run exited with status $run_status"
   exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "Simulation passed"; then
   exit 0
fi
echo "Pass message not found in the simulation output"
exit 1

// ==== verif/periph_soc_tb.sv ====
//********************
// Peripheral block testbench
// bus tasks, UART loopback and bit-banged
// frames, GPIO and memory slot checks
//********************
`timescale 1ns/1ps
`default_nettype none

module periph_soc_tb;

   localparam int BAUD_RESET = 8;
   localparam int TIMEOUT    = 3000;                // cycles or polls per wait

   localparam periph_pkg::addr_t UART_TX =
      {periph_pkg::SLOT_UART, 1'b1, periph_pkg::UART_TX_OFS, 12'h000};  // status on read
   localparam periph_pkg::addr_t UART_POP =
      {periph_pkg::SLOT_UART, 1'b1, periph_pkg::UART_RX_POP_OFS, 12'h000};
   localparam periph_pkg::addr_t UART_BAUD =
      {periph_pkg::SLOT_UART, 1'b1, periph_pkg::UART_BAUD_OFS, 12'h000};
   localparam periph_pkg::addr_t UART_CNT  = {periph_pkg::SLOT_UART, 1'b1, 2'b10, 12'h000};
   localparam periph_pkg::addr_t GPIO_ADDR = {periph_pkg::SLOT_GPIO, 15'h0000};

   logic              clk = 1'b0;
   logic              rstn;
   logic              hid_en;
   periph_pkg::be_t   hid_we;
   periph_pkg::addr_t hid_addr;
   periph_pkg::data_t hid_wrdata;
   periph_pkg::data_t hid_rddata;
   logic              uart_rx;
   logic              uart_tx;
   logic              uart_irq;
   logic [15:0]       leds;
   logic [15:0]       from_dip;
   logic              ram_en;
   periph_pkg::be_t   ram_we;
   logic [15:0]       ram_addr;
   periph_pkg::data_t ram_wrdata;
   periph_pkg::data_t ram_rddata;

   logic              loop_en;                      // rx fed back from tx
   logic              bb_line;                      // bit-banged rx line
   integer            seed = 32'hea65;
   int                errors = 0;
   int                checks = 0;
   logic              timed_out = 1'b0;
   string             timeout_what;
   int                cur_baud = BAUD_RESET;
   logic [11:0]       tx_pushes = '0;
   logic [11:0]       rx_frames = '0;
   logic [11:0]       rx_pops = '0;

   always #10 clk = ~clk;

   assign uart_rx = loop_en ? uart_tx : bb_line;

   periph_soc #(.BAUD_DEFAULT(BAUD_RESET), .FIFO_DEPTH(16)) dut0 (
      .msoc_clk     (clk),
      .rstn         (rstn),
      .hid_en_i     (hid_en),
      .hid_we_i     (hid_we),
      .hid_addr_i   (hid_addr),
      .hid_wrdata_i (hid_wrdata),
      .hid_rddata_o (hid_rddata),
      .uart_rx_i    (uart_rx),
      .uart_tx_o    (uart_tx),
      .uart_irq_o   (uart_irq),
      .leds_o       (leds),
      .from_dip_i   (from_dip),
      .ram_en_o     (ram_en),
      .ram_we_o     (ram_we),
      .ram_addr_o   (ram_addr),
      .ram_wrdata_o (ram_wrdata),
      .ram_rddata_i (ram_rddata)
   );

   // memory strobe only for an access to slot 0 or 1
   a_mem_strobe: assert property (@(posedge clk) disable iff (!rstn)
      ram_en == (hid_en && (hid_addr[17:15] == periph_pkg::SLOT_MEM0 ||
                            hid_addr[17:15] == periph_pkg::SLOT_MEM1)))
   else
   begin
      errors++;
      $display("Error at %0t: ram_en_o does not follow the memory slot decode", $time);
   end

   task automatic check_eq(input periph_pkg::data_t got, input periph_pkg::data_t exp,
                           input string what);
      checks++;
      assert (got === exp)
      else
      begin
         errors++;
         $display("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic abort_wait(input string what);
      timeout_what = what;
      timed_out    = 1'b1;
      forever @(posedge clk);                       // stop process ends the run
   endtask

   task automatic write_bus(input periph_pkg::addr_t addr, input periph_pkg::data_t data);
      @(posedge clk);
      hid_en     <= 1'b1;
      hid_we     <= '1;
      hid_addr   <= addr;
      hid_wrdata <= data;
      @(posedge clk);                               // write sampled here
      hid_en <= 1'b0;
      hid_we <= '0;
   endtask

   task automatic read_bus(input periph_pkg::addr_t addr, output periph_pkg::data_t data);
      @(posedge clk);
      hid_en   <= 1'b1;
      hid_we   <= '0;
      hid_addr <= addr;
      @(negedge clk);
      data = hid_rddata;                            // combinational read data
      @(posedge clk);
      hid_en <= 1'b0;
   endtask

   task automatic wait_irq(input logic level);
      int n = 0;
      while (uart_irq !== level)
      begin
         if (n >= TIMEOUT)
            abort_wait("uart_irq_o to change");
         @(negedge clk);
         n++;
      end
   endtask

   task automatic wait_rx_data();
      periph_pkg::data_t st;
      int n = 0;
      read_bus(UART_TX, st);
      while (st[9])                                 // rx_empty
      begin
         if (n >= TIMEOUT)
            abort_wait("a word in the receive FIFO");
         read_bus(UART_TX, st);
         n++;
      end
   endtask

   task automatic pop_and_check(input logic [7:0] exp_byte, input logic exp_err,
                                input string what);
      periph_pkg::data_t st;
      wait_rx_data();
      read_bus(UART_TX, st);
      check_eq({55'b0, st[8:0]}, {55'b0, exp_err, exp_byte}, what);
      write_bus(UART_POP, '0);
      rx_pops++;
   endtask

   task automatic send_frame(input logic [7:0] data, input logic stop);
      logic [9:0] bits;
      bits = {stop, data, 1'b0};                    // lsb first after the start bit
      @(posedge clk);
      for (int i = 0; i < 10; i++)
      begin
         bb_line <= bits[i];
         repeat (cur_baud) @(posedge clk);
      end
      bb_line <= 1'b1;
      repeat (2 * cur_baud) @(posedge clk);         // idle so the receiver rearms
   endtask

   task automatic measure_start_bit(output int len);
      int n = 0;
      while (uart_tx === 1'b1)
      begin
         if (n >= TIMEOUT)
            abort_wait("the start bit on uart_tx_o");
         @(negedge clk);
         n++;
      end
      len = 0;
      while (uart_tx === 1'b0)
      begin
         if (len >= TIMEOUT)
            abort_wait("the end of the start bit");
         @(negedge clk);
         len++;
      end
   endtask

   task automatic access_slot(input logic [2:0] slot, input periph_pkg::be_t be);
      periph_pkg::addr_t addr;
      periph_pkg::data_t wdata;
      periph_pkg::data_t rdata;
      logic              mem;
      addr  = {slot, 15'($random(seed))};
      wdata = {$random(seed), $random(seed)};
      rdata = {$random(seed), $random(seed)};
      mem   = (slot == periph_pkg::SLOT_MEM0) || (slot == periph_pkg::SLOT_MEM1);
      @(posedge clk);
      ram_rddata <= rdata;
      hid_en     <= 1'b1;
      hid_we     <= be;
      hid_addr   <= addr;
      hid_wrdata <= wdata;
      @(negedge clk);
      check_eq(64'(ram_en), 64'(mem), "ram_en_o");
      if (mem)
      begin
         check_eq(64'(ram_addr), 64'(addr[15:0]), "ram_addr_o");
         check_eq(64'(ram_we), 64'(be), "ram_we_o");
         check_eq(ram_wrdata, wdata, "ram_wrdata_o");
         check_eq(hid_rddata, rdata, "memory slot read data");
      end
      else
         check_eq(hid_rddata, '0, "unused slot read data");
      @(posedge clk);
      hid_en <= 1'b0;
      hid_we <= '0;
   endtask

   initial
   begin
      wait (timed_out);
      $display("Timeout while waiting for %s", timeout_what);
      $display("Simulation failed");
      $finish;
   end

   initial
   begin
      periph_pkg::data_t rd;
      logic [7:0]        b;
      logic [15:0]       val;
      logic [7:0]        sent [$];
      int                len;
      rstn       <= 1'b0;
      hid_en     <= 1'b0;
      hid_we     <= '0;
      hid_addr   <= '0;
      hid_wrdata <= '0;
      from_dip   <= '0;
      ram_rddata <= '0;
      loop_en    <= 1'b0;
      bb_line    <= 1'b1;
      repeat (16) @(posedge clk);
      rstn <= 1'b1;

      // state after reset
      @(negedge clk);
      check_eq(64'(uart_tx), 64'd1, "uart_tx_o after reset");
      check_eq(64'(uart_irq), 64'd0, "uart_irq_o after reset");
      check_eq(64'(leds), 64'd0, "leds_o after reset");
      read_bus(UART_TX, rd);
      check_eq(64'(rd[11:9]), 64'b001, "status flags after reset");
      read_bus(UART_CNT, rd);
      check_eq(rd, '0, "FIFO counts after reset");

      // GPIO slot
      val = 16'($random(seed));
      write_bus(GPIO_ADDR, {48'b0, val});
      @(negedge clk);
      check_eq(64'(leds), 64'(val), "leds_o one cycle after the write");
      val = 16'($random(seed));
      @(posedge clk);
      from_dip <= val;
      repeat (2) @(posedge clk);
      read_bus(GPIO_ADDR, rd);
      check_eq(rd, 64'(val), "DIP switch read");

      // loopback of several bytes
      @(posedge clk);
      loop_en <= 1'b1;
      for (int i = 0; i < 6; i++)
      begin
         b = 8'($random(seed));
         sent.push_back(b);
         write_bus(UART_TX, {56'b0, b});
         tx_pushes++;
         rx_frames++;
      end
      wait_irq(1'b1);
      while (sent.size() > 0)
         pop_and_check(sent.pop_front(), 1'b0, "loopback word");
      @(negedge clk);
      check_eq(64'(uart_irq), 64'd0, "uart_irq_o with the receive FIFO empty");

      // new divisor, start bit length
      cur_baud = 13;
      write_bus(UART_BAUD, 64'(cur_baud));
      b = 8'($random(seed)) | 8'h01;                // data bit 0 high closes the start bit
      write_bus(UART_TX, {56'b0, b});
      tx_pushes++;
      rx_frames++;
      measure_start_bit(len);
      checks++;
      assert (len >= cur_baud - 1 && len <= cur_baud + 1)
      else
      begin
         errors++;
         $display("Error at %0t: start bit lasted %0d clocks, divisor %0d", $time, len, cur_baud);
      end
      pop_and_check(b, 1'b0, "word at the new divisor");

      // framing error, then a clean bit-banged frame
      @(posedge clk);
      loop_en <= 1'b0;
      b = 8'($random(seed));
      send_frame(b, 1'b0);
      rx_frames++;
      pop_and_check(b, 1'b1, "word with a low stop bit");
      b = 8'($random(seed));
      send_frame(b, 1'b1);
      rx_frames++;
      pop_and_check(b, 1'b0, "bit-banged word");
      read_bus(UART_CNT, rd);
      check_eq(rd, {4'h0, tx_pushes, 4'h0, tx_pushes, 4'h0, rx_frames, 4'h0, rx_pops},
               "FIFO counts");

      // memory slots and unused slots
      access_slot(periph_pkg::SLOT_MEM0, '1);
      access_slot(periph_pkg::SLOT_MEM1, 8'h0f);
      access_slot(periph_pkg::SLOT_MEM0, '0);
      access_slot(periph_pkg::SLOT_MEM1, '0);
      access_slot(3'd5, '1);
      access_slot(3'd7, '0);

      repeat (4) @(posedge clk);
      $display("Checks run: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("Simulation passed");
      else
         $display("Simulation failed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== logic/periph_soc.sv ====
//********************
// Peripheral block top level
// host bus to UART, GPIO and memory slots
//********************
`timescale 1ns/1ps
`default_nettype none

module periph_soc #(
   parameter int BAUD_DEFAULT = 54,
   parameter int FIFO_DEPTH   = 16
) (
   input  wire                      msoc_clk,
   input  wire                      rstn,
   input  wire                      hid_en_i,
   input  wire periph_pkg::be_t     hid_we_i,
   input  wire periph_pkg::addr_t   hid_addr_i,
   input  wire periph_pkg::data_t   hid_wrdata_i,
   output periph_pkg::data_t        hid_rddata_o,
   input  wire                      uart_rx_i,
   output logic                     uart_tx_o,
   output logic                     uart_irq_o,
   output logic [15:0]              leds_o,
   input  wire [15:0]               from_dip_i,
   output logic                     ram_en_o,
   output periph_pkg::be_t          ram_we_o,
   output logic [15:0]              ram_addr_o,
   output periph_pkg::data_t        ram_wrdata_o,
   input  wire periph_pkg::data_t   ram_rddata_i
);

   logic              uart_sel;
   periph_pkg::data_t uart_rdata;

   periph_bus_if bus_if ();

   assign bus_if.en     = hid_en_i;
   assign bus_if.we     = hid_we_i;
   assign bus_if.addr   = hid_addr_i;
   assign bus_if.wrdata = hid_wrdata_i;

   periph_decode decode0 (
      .msoc_clk     (msoc_clk),
      .rstn         (rstn),
      .bus          (bus_if.periph),
      .uart_rdata_i (uart_rdata),
      .ram_rddata_i (ram_rddata_i),
      .from_dip_i   (from_dip_i),
      .uart_sel_o   (uart_sel),
      .hid_rddata_o (hid_rddata_o),
      .leds_o       (leds_o),
      .ram_en_o     (ram_en_o),
      .ram_we_o     (ram_we_o),
      .ram_addr_o   (ram_addr_o),
      .ram_wrdata_o (ram_wrdata_o)
   );

   uart_ctrl #(.BAUD_DEFAULT(BAUD_DEFAULT), .FIFO_DEPTH(FIFO_DEPTH)) uart0 (
      .msoc_clk     (msoc_clk),
      .rstn         (rstn),
      .bus          (bus_if.periph),
      .uart_sel_i   (uart_sel),
      .uart_rx_i    (uart_rx_i),
      .uart_tx_o    (uart_tx_o),
      .uart_irq_o   (uart_irq_o),
      .uart_rdata_o (uart_rdata)
   );

endmodule

`default_nettype wire

// ==== logic/periph_decode.sv ====
//********************
// Peripheral slot decode
// read-data merge, LED and DIP registers,
// pass-through to the external memory port
//********************
`timescale 1ns/1ps
`default_nettype none

module periph_decode (
   input  wire                msoc_clk,
   input  wire                rstn,
   periph_bus_if.periph       bus,
   input  wire periph_pkg::data_t uart_rdata_i,
   input  wire periph_pkg::data_t ram_rddata_i,
   input  wire [15:0]         from_dip_i,
   output logic               uart_sel_o,
   output periph_pkg::data_t  hid_rddata_o,
   output logic [15:0]        leds_o,
   output logic               ram_en_o,
   output periph_pkg::be_t    ram_we_o,
   output logic [15:0]        ram_addr_o,
   output periph_pkg::data_t  ram_wrdata_o
);

   logic [2:0]  slot;
   logic        mem_sel;
   logic        gpio_wr;
   logic [15:0] dip_q;

   assign slot    = bus.addr[17:15];
   assign mem_sel = (slot == periph_pkg::SLOT_MEM0) || (slot == periph_pkg::SLOT_MEM1);
   assign gpio_wr = bus.en && (|bus.we) && (slot == periph_pkg::SLOT_GPIO);

   assign uart_sel_o = (slot == periph_pkg::SLOT_UART);  // address only, uart checks en

   // memory slots go straight out
   assign ram_en_o     = bus.en && mem_sel;
   assign ram_we_o     = bus.we;
   assign ram_addr_o   = bus.addr[15:0];
   assign ram_wrdata_o = bus.wrdata;

   always_ff @(posedge msoc_clk or negedge rstn)
   begin
      if (!rstn)
      begin
         leds_o <= '0;
         dip_q  <= '0;
      end
      else
      begin
         dip_q <= from_dip_i;                       // one stage on the switches
         if (gpio_wr)
            leds_o <= bus.wrdata[15:0];
      end
   end

   always_comb
   begin
      case (slot)
         periph_pkg::SLOT_MEM0, periph_pkg::SLOT_MEM1: hid_rddata_o = ram_rddata_i;
         periph_pkg::SLOT_GPIO: hid_rddata_o = {{(periph_pkg::DATA_W-16){1'b0}}, dip_q};
         periph_pkg::SLOT_UART: hid_rddata_o = uart_rdata_i;
         default:               hid_rddata_o = '0;  // unused slots
      endcase
   end

   // the memory port, GPIO and UART never see the same access
   a_one_slot: assert property (@(posedge msoc_clk) disable iff (!rstn)
      $onehot0({ram_en_o, gpio_wr, uart_sel_o && bus.en}));

endmodule

`default_nettype wire

// ==== logic/uart_ctrl.sv ====
//********************
// UART register slot
// transmit and receive FIFOs, baud register,
// status read-back and the transmit sequencer
//********************
`timescale 1ns/1ps
`default_nettype none

module uart_ctrl #(
   parameter int BAUD_DEFAULT = 54,
   parameter int FIFO_DEPTH   = 16
) (
   input  wire                msoc_clk,
   input  wire                rstn,
   periph_bus_if.periph       bus,
   input  wire                uart_sel_i,
   input  wire                uart_rx_i,
   output logic               uart_tx_o,
   output logic               uart_irq_o,
   output periph_pkg::data_t  uart_rdata_o
);

   localparam int CNT_PAD = 16 - periph_pkg::FIFO_CNT_W;

   logic                   wr_hit, tx_push, rx_pop;
   logic [1:0]             sub_ofs;
   periph_pkg::baud_t      baud_q;
   periph_pkg::utx_state_t state_q, state_d;
   logic [7:0]             tx_dout, tx_byte_q;
   logic                   tx_full, tx_empty, rx_full, rx_empty;
   periph_pkg::uart_word_t rx_dout, rx_word;
   logic                   rx_valid, tx_busy, tx_start;
   periph_pkg::fifo_cnt_t  tx_wrcount, tx_rdcount, rx_wrcount, rx_rdcount;

   assign sub_ofs = bus.addr[13:12];
   assign wr_hit  = bus.en && (|bus.we) && uart_sel_i && bus.addr[14];
   assign tx_push = wr_hit && (sub_ofs == periph_pkg::UART_TX_OFS);
   assign rx_pop  = wr_hit && (sub_ofs == periph_pkg::UART_RX_POP_OFS);

   assign tx_start   = (state_q == periph_pkg::UTX_START);
   assign uart_irq_o = !rx_empty;

   always_ff @(posedge msoc_clk or negedge rstn)
   begin
      if (!rstn)
      begin
         baud_q  <= periph_pkg::baud_t'(BAUD_DEFAULT);
         state_q <= periph_pkg::UTX_IDLE;
      end
      else
      begin
         state_q <= state_d;
         if (wr_hit && (sub_ofs == periph_pkg::UART_BAUD_OFS))
            baud_q <= bus.wrdata[periph_pkg::BAUD_W-1:0];
      end
   end

   // head byte is captured as it leaves the FIFO
   always_ff @(posedge msoc_clk)
   begin
      if (state_q == periph_pkg::UTX_POP)
         tx_byte_q <= tx_dout;
   end

   always_comb
   begin
      state_d = state_q;
      case (state_q)
         periph_pkg::UTX_IDLE:  state_d = periph_pkg::UTX_EMPTY;
         periph_pkg::UTX_EMPTY: if (!tx_empty) state_d = periph_pkg::UTX_POP;
         periph_pkg::UTX_POP:   state_d = periph_pkg::UTX_START;
         periph_pkg::UTX_START: state_d = periph_pkg::UTX_INUSE;
         periph_pkg::UTX_INUSE: if (!tx_busy) state_d = periph_pkg::UTX_IDLE;  // frame done
         default:               state_d = periph_pkg::UTX_IDLE;
      endcase
   end

   always_comb
   begin
      if (!bus.addr[14])
         uart_rdata_o = '0;
      else if (bus.addr[13])
         uart_rdata_o = {{CNT_PAD{1'b0}}, tx_wrcount, {CNT_PAD{1'b0}}, tx_rdcount,
                         {CNT_PAD{1'b0}}, rx_wrcount, {CNT_PAD{1'b0}}, rx_rdcount};
      else
         uart_rdata_o = {52'b0, rx_full, tx_full, rx_empty, rx_dout};
   end

   uart_fifo #(.WIDTH(8), .DEPTH(FIFO_DEPTH)) tx_fifo (
      .msoc_clk  (msoc_clk),
      .rstn      (rstn),
      .din_i     (bus.wrdata[7:0]),
      .wr_en_i   (tx_push),
      .rd_en_i   (state_q == periph_pkg::UTX_POP),
      .dout_o    (tx_dout),
      .full_o    (tx_full),
      .empty_o   (tx_empty),
      .rdcount_o (tx_rdcount),
      .wrcount_o (tx_wrcount)
   );

   uart_fifo #(.WIDTH($bits(periph_pkg::uart_word_t)), .DEPTH(FIFO_DEPTH)) rx_fifo (
      .msoc_clk  (msoc_clk),
      .rstn      (rstn),
      .din_i     (rx_word),
      .wr_en_i   (rx_valid),
      .rd_en_i   (rx_pop),
      .dout_o    (rx_dout),
      .full_o    (rx_full),
      .empty_o   (rx_empty),
      .rdcount_o (rx_rdcount),
      .wrcount_o (rx_wrcount)
   );

   uart_serial serial0 (
      .msoc_clk   (msoc_clk),
      .rstn       (rstn),
      .baud_i     (baud_q),
      .rx_i       (uart_rx_i),
      .tx_o       (uart_tx_o),
      .tx_start_i (tx_start),
      .tx_byte_i  (tx_byte_q),
      .tx_busy_o  (tx_busy),
      .rx_valid_o (rx_valid),
      .rx_word_o  (rx_word)
   );

   // the sequencer never starts a frame over a running one
   a_start_idle: assert property (@(posedge msoc_clk) disable iff (!rstn)
      tx_start |-> !tx_busy);

endmodule

`default_nettype wire

// ==== logic/uart_serial.sv ====
//********************
// UART serializer and deserializer
// 8N1 frames, programmable divisor,
// majority-filtered receive line
//********************
`timescale 1ns/1ps
`default_nettype none

module uart_serial (
   input  wire                     msoc_clk,
   input  wire                     rstn,
   input  wire periph_pkg::baud_t  baud_i,
   input  wire                     rx_i,
   output logic                    tx_o,
   input  wire                     tx_start_i,
   input  wire [7:0]               tx_byte_i,
   output logic                    tx_busy_o,
   output logic                    rx_valid_o,
   output periph_pkg::uart_word_t  rx_word_o
);

   typedef enum logic [2:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP, RX_WAIT} rx_state_t;

   logic [2:0]        rx_taps;
   logic              rx_maj;
   periph_pkg::baud_t bit_len;

   periph_pkg::baud_t tx_cnt;
   logic [3:0]        tx_bit;
   logic [9:0]        tx_shift;

   rx_state_t         rx_state;
   periph_pkg::baud_t rx_cnt;
   logic [2:0]        rx_bit;
   logic [7:0]        rx_shift;

   assign bit_len = baud_i - periph_pkg::baud_t'(1);
   assign rx_maj  = (rx_taps[0] & rx_taps[1]) | (rx_taps[0] & rx_taps[2]) |
                    (rx_taps[1] & rx_taps[2]);      // 2 of 3 vote

   assign tx_o = tx_busy_o ? tx_shift[0] : 1'b1;    // idle high

   // transmitter control
   always_ff @(posedge msoc_clk or negedge rstn)
   begin
      if (!rstn)
      begin
         tx_busy_o <= 1'b0;
         tx_cnt    <= '0;
         tx_bit    <= '0;
      end
      else if (!tx_busy_o)
      begin
         if (tx_start_i)
         begin
            tx_busy_o <= 1'b1;
            tx_cnt    <= bit_len;
            tx_bit    <= '0;
         end
      end
      else if (tx_cnt != '0)
         tx_cnt <= tx_cnt - 1'b1;
      else if (tx_bit == 4'd9)
         tx_busy_o <= 1'b0;                         // stop bit done
      else
      begin
         tx_cnt <= bit_len;
         tx_bit <= tx_bit + 1'b1;
      end
   end

   always_ff @(posedge msoc_clk)
   begin
      if (!tx_busy_o && tx_start_i)
         tx_shift <= {1'b1, tx_byte_i, 1'b0};       // stop, data lsb first, start
      else if (tx_busy_o && tx_cnt == '0)
         tx_shift <= {1'b1, tx_shift[9:1]};
   end

   // receiver control
   always_ff @(posedge msoc_clk or negedge rstn)
   begin
      if (!rstn)
      begin
         rx_taps    <= 3'b111;
         rx_state   <= RX_IDLE;
         rx_cnt     <= '0;
         rx_bit     <= '0;
         rx_valid_o <= 1'b0;
      end
      else
      begin
         rx_taps    <= {rx_taps[1:0], rx_i};
         rx_valid_o <= 1'b0;
         if (rx_state != RX_IDLE && rx_state != RX_WAIT && rx_cnt != '0)
            rx_cnt <= rx_cnt - 1'b1;
         else
         begin
            case (rx_state)
               RX_IDLE:
                  if (!rx_maj)
                  begin
                     rx_state <= RX_START;
                     rx_cnt   <= baud_i >> 1;       // aim at mid start bit
                  end
               RX_START:
                  if (!rx_maj)
                  begin
                     rx_state <= RX_DATA;
                     rx_cnt   <= bit_len;
                     rx_bit   <= '0;
                  end
                  else
                     rx_state <= RX_IDLE;           // glitch, not a start
               RX_DATA:
               begin
                  rx_cnt <= bit_len;
                  rx_bit <= rx_bit + 1'b1;
                  if (rx_bit == 3'd7)
                     rx_state <= RX_STOP;
               end
               RX_STOP:
               begin
                  rx_valid_o <= 1'b1;
                  rx_state   <= rx_maj ? RX_IDLE : RX_WAIT;
               end
               RX_WAIT:
                  if (rx_maj)
                     rx_state <= RX_IDLE;           // line back high after bad stop
               default:
                  rx_state <= RX_IDLE;
            endcase
         end
      end
   end

   always_ff @(posedge msoc_clk)
   begin
      if (rx_state == RX_DATA && rx_cnt == '0)
         rx_shift <= {rx_maj, rx_shift[7:1]};
      if (rx_state == RX_STOP && rx_cnt == '0)
         rx_word_o <= {!rx_maj, rx_shift};          // low stop flags an error
   end

endmodule

`default_nettype wire

// ==== logic/uart_fifo.sv ====
//********************
// UART FIFO, first word fall through
// free-running push and pop counts
//********************
`timescale 1ns/1ps
`default_nettype none

module uart_fifo #(
   parameter int WIDTH = 9,
   parameter int DEPTH = 16                         // power of two
) (
   input  wire                   msoc_clk,
   input  wire                   rstn,
   input  wire [WIDTH-1:0]       din_i,
   input  wire                   wr_en_i,
   input  wire                   rd_en_i,
   output logic [WIDTH-1:0]      dout_o,
   output logic                  full_o,
   output logic                  empty_o,
   output periph_pkg::fifo_cnt_t rdcount_o,
   output periph_pkg::fifo_cnt_t wrcount_o
);

   localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

   logic [WIDTH-1:0]      mem [DEPTH];
   periph_pkg::fifo_cnt_t used;
   logic                  push, pop;

   assign used    = wrcount_o - rdcount_o;          // wraps cleanly, DEPTH is far below 4096
   assign empty_o = (used == '0);
   assign full_o  = (used == periph_pkg::fifo_cnt_t'(DEPTH));
   assign push    = wr_en_i && !full_o;
   assign pop     = rd_en_i && !empty_o;

   assign dout_o = mem[rdcount_o[AW-1:0]];          // head entry

   always_ff @(posedge msoc_clk or negedge rstn)
   begin
      if (!rstn)
      begin
         wrcount_o <= '0;
         rdcount_o <= '0;
      end
      else
      begin
         if (push)
            wrcount_o <= wrcount_o + 1'b1;
         if (pop)
            rdcount_o <= rdcount_o + 1'b1;
      end
   end

   always_ff @(posedge msoc_clk)
   begin
      if (push)
         mem[wrcount_o[AW-1:0]] <= din_i;
   end

   a_no_overflow: assert property (@(posedge msoc_clk) disable iff (!rstn)
      wr_en_i |-> !full_o);
   a_no_underflow: assert property (@(posedge msoc_clk) disable iff (!rstn)
      rd_en_i |-> !empty_o);

endmodule

`default_nettype wire

// ==== logic/periph_bus_if.sv ====
//********************
// Host bus into the peripheral block
// plain strobes, read data returned
// combinationally outside the interface
//********************
`timescale 1ns/1ps
`default_nettype none

interface periph_bus_if;

   logic                en;                         // access strobe
   periph_pkg::be_t     we;                         // byte write enables
   periph_pkg::addr_t   addr;
   periph_pkg::data_t   wrdata;

   // all peripheral slots only listen to the host
   modport periph (
      input en,
      input we,
      input addr,
      input wrdata
   );

endinterface

`default_nettype wire

// ==== logic/periph_pkg.sv ====
//********************
// Peripheral block shared definitions
// slot map, UART offsets, widths and the
// transmit sequencer state encoding
//********************
`default_nettype none

package periph_pkg;

   localparam int ADDR_W = 18;                      // host address width
   localparam int DATA_W = 64;
   localparam int BE_W   = 8;                       // one enable per byte

   typedef logic [ADDR_W-1:0] addr_t;
   typedef logic [DATA_W-1:0] data_t;
   typedef logic [BE_W-1:0]   be_t;

   // slot number in addr[17:15]
   localparam logic [2:0] SLOT_MEM0 = 3'd0;
   localparam logic [2:0] SLOT_MEM1 = 3'd1;
   localparam logic [2:0] SLOT_GPIO = 3'd2;
   localparam logic [2:0] SLOT_UART = 3'd6;

   // sub-offset in addr[13:12], valid with addr[14] set
   localparam logic [1:0] UART_TX_OFS     = 2'd0;
   localparam logic [1:0] UART_RX_POP_OFS = 2'd1;
   localparam logic [1:0] UART_BAUD_OFS   = 2'd2;

   localparam int FIFO_CNT_W = 12;
   typedef logic [FIFO_CNT_W-1:0] fifo_cnt_t;

   localparam int BAUD_W = 16;                      // clocks per bit
   typedef logic [BAUD_W-1:0] baud_t;

   typedef enum logic [2:0] {UTX_IDLE, UTX_EMPTY, UTX_POP, UTX_START, UTX_INUSE} utx_state_t;

   typedef logic [8:0] uart_word_t;                 // {frame_err, byte}

endpackage

`default_nettype wire
